// File: vlog.f
verilog/cmd_pkg.sv
verilog/cmd_collect.sv
verilog/chain_ctrl.sv
verilog/scope_settings.sv
verilog/reply_tx.sv
verilog/board_cmd_top.sv
bench/board_cmd_tb.sv

// File: Bender.yml
package:
  name: board_cmd

sources:
  - verilog/cmd_pkg.sv
  - verilog/cmd_collect.sv
  - verilog/chain_ctrl.sv
  - verilog/scope_settings.sv
  - verilog/reply_tx.sv
  - verilog/board_cmd_top.sv
  - target: test
    files:
      - bench/board_cmd_tb.sv

// File: bench/board_cmd_tb.sv
// testbench for board_cmd_top with clock, reset, uart stub, random commands, reference model and checks
`timescale 1ns/10ps

module board_cmd_tb;

	localparam int TIMEOUT = 2000; // cycles allowed for any single wait

	logic        clk = 1'b0;
	logic        arst_n;
	logic        rx_ready;
	logic [7:0]  rx_data;
	logic        tx_busy;
	logic [63:0] chip_id;
	logic [7:0]  delaycounter;
	logic [7:0]  carrycounter;
	logic        tx_start;
	logic [7:0]  tx_data;
	logic        com_valid;
	logic [7:0]  com_data;
	logic [7:0]  my_id;
	logic        master_clock;
	logic        first_board;
	logic        last_board;
	logic        passthrough;
	logic [7:0]  trigthresh;
	logic [7:0]  trigthresh2;
	logic [3:0]  triggertype;
	logic [3:0]  trigchannels;
	logic [12:0] triggertot;
	logic [11:0] triggerpoint;
	logic [11:0] nsmp;
	logic [7:0]  downsample;
	logic        rollingtrigger;
	logic        highres;
	logic        use_ext_trig;
	logic        spi_send;
	logic [15:0] spi_data;
	logic        prime_trigger;

	// reference model state
	logic [7:0]  m_id;
	logic        m_master;
	logic        m_last;
	logic        m_pt;
	logic [7:0]  m_th;
	logic [7:0]  m_th2;
	logic [3:0]  m_ttype;
	logic [3:0]  m_tchan;
	logic [12:0] m_tot;
	logic [11:0] m_tp;
	logic [11:0] m_nsmp;
	logic [7:0]  m_ds;
	logic        m_roll;
	logic        m_hr;
	logic        m_ext;

	logic [7:0]  exp_fwd[$]; // expected chain bytes
	logic [7:0]  got_fwd[$];
	logic [7:0]  exp_tx[$];  // expected uart reply bytes
	logic [7:0]  got_tx[$];
	logic [15:0] exp_spi[$];
	logic [15:0] got_spi[$];
	logic [7:0]  known_ops[22];
	logic [7:0]  op;
	logic        busy_prev = 1'b0;
	int          n_prime = 0;
	int          exp_prime = 0;
	int          checks = 0;
	int          errors = 0;
	int          err_base = 0; // error count when the current test began

	board_cmd_top UUT (.*);

	always #10 clk = ~clk; // 20 ns period

	// output monitor sampling mid-cycle
	always @(negedge clk) begin
		if (com_valid)
			got_fwd.push_back(com_data);
		if (tx_start) begin
			got_tx.push_back(tx_data);
			compare("tx_busy before tx_start", busy_prev, 1'b0); // dut saw it low
		end
		if (spi_send)
			got_spi.push_back(spi_data);
		if (prime_trigger)
			n_prime++;
		busy_prev = tx_busy;
	end

	// uart stub holds busy for 3 to 12 cycles per byte
	initial begin
		tx_busy = 1'b0;
		forever begin
			@(negedge clk);
			if (tx_start) begin
				@(posedge clk);
				#2 tx_busy = 1'b1;
				repeat (3 + $urandom % 10) @(posedge clk);
				#2 tx_busy = 1'b0;
			end
		end
	end

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timed out after %0d cycles waiting for %s", TIMEOUT, what);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	task automatic wait_tx_count(input int n);
		int cyc;
		cyc = 0;
		while (got_tx.size() < n) begin
			@(posedge clk);
			cyc++;
			if (cyc > TIMEOUT)
				timeout_fail("reply bytes from the uart transmitter");
		end
	endtask

	task automatic wait_tx_idle();
		int cyc;
		cyc = 0;
		do begin
			@(negedge clk);
			cyc++;
			if (cyc > TIMEOUT)
				timeout_fail("the reply transmitter to go idle");
		end while (tx_busy || UUT.reply_busy); // rx bytes are dropped until reply_busy falls
	endtask

	task automatic send_byte(input logic [7:0] b);
		@(posedge clk);
		#2;
		rx_ready = 1'b1;
		rx_data = b;
		@(posedge clk);
		#2;
		rx_ready = 1'b0;
		repeat ($urandom % 4) @(posedge clk); // random idle gap
	endtask

	function automatic int nargs(input logic [7:0] code);
		case (code)
			cmd_pkg::OP_PRIME, cmd_pkg::OP_ROLL_ON, cmd_pkg::OP_ROLL_OFF, cmd_pkg::OP_HIGHRES,
			cmd_pkg::OP_EXT_TRIG, cmd_pkg::OP_DELAY_CNT, cmd_pkg::OP_CARRY_CNT,
			cmd_pkg::OP_CHIP_ID, cmd_pkg::OP_FW_VER: return 0;
			cmd_pkg::OP_TRIG_POINT, cmd_pkg::OP_NSMP, cmd_pkg::OP_TOT, cmd_pkg::OP_SPI: return 2;
			cmd_pkg::OP_SET_ID, cmd_pkg::OP_READ_SEL, cmd_pkg::OP_SET_LAST, cmd_pkg::OP_ACTIVE_SEL,
			cmd_pkg::OP_DOWNSAMPLE, cmd_pkg::OP_THRESH, cmd_pkg::OP_TRIG_TYPE,
			cmd_pkg::OP_TRIG_CHAN, cmd_pkg::OP_THRESH2: return 1;
			default: return 3; // ignored opcode
		endcase
	endfunction

	// model of the chain state and setting registers
	task automatic apply_cmd(input logic [7:0] code, input logic [15:0] w);
		logic [7:0] a;
		a = w[7:0];
		case (code)
			cmd_pkg::OP_SET_ID: begin
				m_id = a;
				m_master = (a != 8'd0);
			end
			cmd_pkg::OP_SET_LAST: m_last = (a == m_id);
			cmd_pkg::OP_READ_SEL: begin
				if (a == m_id || a == cmd_pkg::BROADCAST_ID)
					m_pt = 1'b0;
				else if (m_id < a)
					m_pt = 1'b1;
			end
			cmd_pkg::OP_ACTIVE_SEL: begin
				if (a == m_id)
					m_pt = 1'b0;
				else if (m_id < a)
					m_pt = 1'b1;
			end
			cmd_pkg::OP_TRIG_POINT: begin
				if (w > cmd_pkg::TRIG_POINT_MAX)
					m_tp = cmd_pkg::TRIG_POINT_MAX;
				else if (w < cmd_pkg::TRIG_POINT_MIN)
					m_tp = cmd_pkg::TRIG_POINT_MIN;
				else
					m_tp = w[11:0];
			end
			cmd_pkg::OP_NSMP: begin
				m_nsmp = w[11:0];
				if (int'(m_tp) > int'(m_nsmp) - 5)
					m_tp = m_nsmp / 2;
			end
			cmd_pkg::OP_DOWNSAMPLE: m_ds = (a > cmd_pkg::DOWNSAMPLE_MAX) ? cmd_pkg::DOWNSAMPLE_MAX : a;
			cmd_pkg::OP_THRESH: m_th = a;
			cmd_pkg::OP_THRESH2: m_th2 = a;
			cmd_pkg::OP_TRIG_TYPE: m_ttype = a[3:0];
			cmd_pkg::OP_TOT: m_tot = w[12:0];
			cmd_pkg::OP_TRIG_CHAN: begin
				if (a / 4 == m_id)
					m_tchan[a % 4] = ~m_tchan[a % 4];
			end
			cmd_pkg::OP_SPI: exp_spi.push_back({1'b0, w[14:0]});
			cmd_pkg::OP_PRIME: exp_prime++;
			cmd_pkg::OP_ROLL_ON: m_roll = 1'b1;
			cmd_pkg::OP_ROLL_OFF: m_roll = 1'b0;
			cmd_pkg::OP_HIGHRES: m_hr = ~m_hr;
			cmd_pkg::OP_EXT_TRIG: m_ext = ~m_ext;
			default: begin
			end
		endcase
	endtask

	task automatic expect_reply(input logic [7:0] code);
		case (code)
			cmd_pkg::OP_CHIP_ID: begin
				for (int i = 0; i < 8; i++)
					exp_tx.push_back(chip_id[8*i +: 8]); // low byte first
			end
			cmd_pkg::OP_FW_VER: exp_tx.push_back(cmd_pkg::FW_VERSION);
			cmd_pkg::OP_DELAY_CNT: exp_tx.push_back(delaycounter);
			default: exp_tx.push_back(carrycounter);
		endcase
		wait_tx_count(exp_tx.size());
		wait_tx_idle();
	endtask

	task automatic send_cmd(input logic [7:0] code, input logic [7:0] a1, input logic [7:0] a2);
		int n;
		logic reply;
		n = nargs(code);
		reply = code inside {cmd_pkg::OP_DELAY_CNT, cmd_pkg::OP_CARRY_CNT, cmd_pkg::OP_CHIP_ID,
			cmd_pkg::OP_FW_VER};
		chip_id = {$urandom, $urandom}; // fresh readout values per command
		delaycounter = $urandom;
		carrycounter = $urandom;
		send_byte(code);
		if (n == 3)
			return; // dropped with nothing forwarded
		if (!reply || m_pt)
			exp_fwd.push_back(code);
		if (n >= 1) begin
			send_byte(a1);
			exp_fwd.push_back((code == cmd_pkg::OP_SET_ID) ? a1 + 8'd1 : a1);
		end
		if (n == 2) begin
			send_byte(a2);
			exp_fwd.push_back(a2);
		end
		if (reply && !m_pt)
			expect_reply(code);
		else if (!reply)
			apply_cmd(code, (n == 2) ? {a1, a2} : {8'h00, a1});
	endtask

	task automatic check_chain();
		compare("my_id", my_id, m_id);
		compare("master_clock", master_clock, m_master);
		compare("first_board", first_board, m_id == 8'd0);
		compare("last_board", last_board, m_last);
		compare("passthrough", passthrough, m_pt);
	endtask

	task automatic check_settings();
		compare("trigthresh", trigthresh, m_th);
		compare("trigthresh2", trigthresh2, m_th2);
		compare("triggertype", triggertype, m_ttype);
		compare("trigchannels", trigchannels, m_tchan);
		compare("triggertot", triggertot, m_tot);
		compare("triggerpoint", triggerpoint, m_tp);
		compare("nsmp", nsmp, m_nsmp);
		compare("downsample", downsample, m_ds);
		compare("rollingtrigger", rollingtrigger, m_roll);
		compare("highres", highres, m_hr);
		compare("use_ext_trig", use_ext_trig, m_ext);
	endtask

	task automatic end_test(input string name);
		repeat (3) @(negedge clk); // let the last strobes land
		compare("com_data count", got_fwd.size(), exp_fwd.size());
		for (int i = 0; i < exp_fwd.size() && i < got_fwd.size(); i++)
			compare("com_data", got_fwd[i], exp_fwd[i]);
		compare("tx_data count", got_tx.size(), exp_tx.size());
		for (int i = 0; i < exp_tx.size() && i < got_tx.size(); i++)
			compare("tx_data", got_tx[i], exp_tx[i]);
		compare("spi_send count", got_spi.size(), exp_spi.size());
		for (int i = 0; i < exp_spi.size() && i < got_spi.size(); i++)
			compare("spi_data", got_spi[i], exp_spi[i]);
		compare("prime_trigger count", n_prime, exp_prime);
		check_chain();
		check_settings();
		$display("%s: %s, %0d errors", name, (errors == err_base) ? "ok" : "failed",
			errors - err_base);
		err_base = errors;
		exp_fwd.delete();
		got_fwd.delete();
		exp_tx.delete();
		got_tx.delete();
		exp_spi.delete();
		got_spi.delete();
		n_prime = 0;
		exp_prime = 0;
		#2;
	endtask

	initial begin
		void'($urandom(54096));
		known_ops = '{cmd_pkg::OP_SET_ID, cmd_pkg::OP_SET_LAST, cmd_pkg::OP_READ_SEL,
			cmd_pkg::OP_ACTIVE_SEL, cmd_pkg::OP_TRIG_POINT, cmd_pkg::OP_NSMP,
			cmd_pkg::OP_DOWNSAMPLE, cmd_pkg::OP_THRESH, cmd_pkg::OP_TRIG_TYPE, cmd_pkg::OP_TOT,
			cmd_pkg::OP_TRIG_CHAN, cmd_pkg::OP_THRESH2, cmd_pkg::OP_HIGHRES,
			cmd_pkg::OP_EXT_TRIG, cmd_pkg::OP_ROLL_ON, cmd_pkg::OP_ROLL_OFF, // 4..15 settings
			cmd_pkg::OP_SPI, cmd_pkg::OP_PRIME, cmd_pkg::OP_DELAY_CNT, cmd_pkg::OP_CARRY_CNT,
			cmd_pkg::OP_CHIP_ID, cmd_pkg::OP_FW_VER};
		arst_n = 1'b0;
		rx_ready = 1'b0;
		rx_data = 8'h00;
		chip_id = '0;
		delaycounter = 8'h00;
		carrycounter = 8'h00;
		m_id = cmd_pkg::RESET_ID;
		m_master = 1'b0;
		m_last = 1'b0;
		m_pt = 1'b0;
		m_th = cmd_pkg::THRESH_RST;
		m_th2 = cmd_pkg::THRESH2_RST;
		m_ttype = cmd_pkg::TRIG_TYPE_RST;
		m_tchan = cmd_pkg::TRIG_CHAN_RST;
		m_tot = '0;
		m_tp = cmd_pkg::TRIG_POINT_RST;
		m_nsmp = '0;
		m_ds = 8'd1;
		m_roll = 1'b1; // free running after reset
		m_hr = 1'b0;
		m_ext = 1'b0;
		repeat (8) @(posedge clk);
		#2 arst_n = 1'b1;

		for (int i = 0; i < 60; i++) begin
			if ($urandom % 5 == 0)
				op = $urandom; // mostly unknown opcodes
			else
				op = known_ops[$urandom % 22];
			send_cmd(op, $urandom, $urandom);
		end
		end_test("chain forwarding");

		for (int i = 0; i < 40; i++) begin
			op = known_ops[$urandom % 4];
			send_cmd(op, ($urandom % 8 == 0) ? 8'd255 : $urandom % 12, 8'h00);
			repeat (2) @(negedge clk);
			check_chain();
		end
		end_test("chain state");

		send_cmd(cmd_pkg::OP_SET_ID, $urandom % 4, 8'h00); // small id so channel toggles hit
		send_cmd(cmd_pkg::OP_TRIG_POINT, 8'h00, 8'h02); // below the minimum
		send_cmd(cmd_pkg::OP_TRIG_POINT, 8'h13, 8'h88); // above the maximum
		for (int i = 0; i < 4; i++)
			send_cmd(cmd_pkg::OP_TRIG_CHAN, {m_id[5:0], i[1:0]}, 8'h00); // channels of this board
		for (int i = 0; i < 80; i++) begin
			op = known_ops[4 + $urandom % 12];
			send_cmd(op, ($urandom % 2) ? $urandom % 40 : $urandom, $urandom);
			repeat (2) @(negedge clk);
			check_settings();
		end
		end_test("settings");

		for (int i = 0; i < 12; i++)
			send_cmd(known_ops[16 + $urandom % 2], $urandom, $urandom);
		end_test("strobes");

		send_cmd(cmd_pkg::OP_READ_SEL, cmd_pkg::BROADCAST_ID, 8'h00); // this board answers
		for (int i = 0; i < 8; i++)
			send_cmd(known_ops[18 + $urandom % 4], 8'h00, 8'h00);
		send_cmd(cmd_pkg::OP_SET_ID, 8'd3, 8'h00);
		send_cmd(cmd_pkg::OP_READ_SEL, 8'd9, 8'h00); // board 9 is further down
		for (int i = 0; i < 8; i++)
			send_cmd(known_ops[18 + $urandom % 4], 8'h00, 8'h00);
		end_test("replies");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: verilog/board_cmd_top.sv
// board command processor top: collector, chain state, settings and reply transmitter
`timescale 1ns/10ps

module board_cmd_top (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          rx_ready,
	input  logic [cmd_pkg::BYTE_W-1:0]    rx_data,
	input  logic                          tx_busy,
	input  logic [cmd_pkg::CHIP_ID_W-1:0] chip_id,
	input  logic [cmd_pkg::BYTE_W-1:0]    delaycounter,
	input  logic [cmd_pkg::BYTE_W-1:0]    carrycounter,
	output logic                          tx_start,
	output logic [cmd_pkg::BYTE_W-1:0]    tx_data,
	output logic                          com_valid,    // to the next board
	output logic [cmd_pkg::BYTE_W-1:0]    com_data,
	output logic [cmd_pkg::BYTE_W-1:0]    my_id,
	output logic                          master_clock,
	output logic                          first_board,
	output logic                          last_board,
	output logic                          passthrough,
	output logic [cmd_pkg::BYTE_W-1:0]    trigthresh,
	output logic [cmd_pkg::BYTE_W-1:0]    trigthresh2,
	output logic [cmd_pkg::N_CHAN-1:0]    triggertype,
	output logic [cmd_pkg::N_CHAN-1:0]    trigchannels,
	output logic [cmd_pkg::TOT_W-1:0]     triggertot,
	output logic [cmd_pkg::RAM_W-1:0]     triggerpoint,
	output logic [cmd_pkg::RAM_W-1:0]     nsmp,
	output logic [cmd_pkg::BYTE_W-1:0]    downsample,
	output logic                          rollingtrigger,
	output logic                          highres,
	output logic                          use_ext_trig,
	output logic                          spi_send,
	output logic [2*cmd_pkg::BYTE_W-1:0]  spi_data,
	output logic                          prime_trigger
);

	// command bus from the collector to the three consumers
	logic                          cmd_valid;
	logic [cmd_pkg::BYTE_W-1:0]    cmd_op;
	cmd_pkg::arg_word_u            cmd_arg;
	logic                          reply_busy; // holds off rx while answering

	// every port name matches a top-level signal
	cmd_collect u_collect (.*);

	chain_ctrl u_chain (.*);

	scope_settings u_settings (.*);

	reply_tx u_reply (.*);

endmodule

// File: verilog/reply_tx.sv
// readout reply byte selection and uart transmit sequencing
`timescale 1ns/10ps

module reply_tx (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          cmd_valid,
	input  logic [cmd_pkg::BYTE_W-1:0]    cmd_op,
	input  logic                          tx_busy,
	input  logic [cmd_pkg::CHIP_ID_W-1:0] chip_id,
	input  logic [cmd_pkg::BYTE_W-1:0]    delaycounter, // tdc counts
	input  logic [cmd_pkg::BYTE_W-1:0]    carrycounter,
	output logic                          tx_start,
	output logic [cmd_pkg::BYTE_W-1:0]    tx_data,
	output logic                          reply_busy
);

	logic [cmd_pkg::CHIP_ID_W-1:0] load_word; // reply bytes, first one in the low byte
	logic [3:0]                    load_cnt;
	logic [cmd_pkg::CHIP_ID_W-1:0] data_q;    // shifts right one byte per send
	logic [3:0]                    left_q;    // bytes not yet started
	logic                          active_q;
	logic                          hold_q;    // cycle right after a start, tx_busy not valid yet
	logic                          start_new;

	always_comb begin
		load_word = '0;
		load_cnt = 4'd1;
		case (cmd_op)
			cmd_pkg::OP_CHIP_ID: begin
				load_word = chip_id; // lsb first
				load_cnt = 4'd8;
			end
			cmd_pkg::OP_FW_VER: load_word[cmd_pkg::BYTE_W-1:0] = cmd_pkg::FW_VERSION;
			cmd_pkg::OP_DELAY_CNT: load_word[cmd_pkg::BYTE_W-1:0] = delaycounter;
			cmd_pkg::OP_CARRY_CNT: load_word[cmd_pkg::BYTE_W-1:0] = carrycounter;
			default: begin
			end
		endcase
	end

	assign start_new = cmd_valid && cmd_pkg::is_reply_op(cmd_op) && !active_q;
	assign reply_busy = active_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active_q <= 1'b0;
			hold_q <= 1'b0;
			left_q <= 4'd0;
			tx_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			if (start_new) begin
				active_q <= 1'b1;
				hold_q <= 1'b0;
				left_q <= load_cnt;
			end else if (active_q) begin
				if (hold_q) begin
					hold_q <= 1'b0; // give the uart a cycle to raise busy
				end else if (!tx_busy) begin
					if (left_q != 4'd0) begin
						tx_start <= 1'b1;
						hold_q <= 1'b1;
						left_q <= left_q - 4'd1;
					end else begin
						active_q <= 1'b0; // last byte is out
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_new)
			data_q <= load_word;
		else if (active_q && !hold_q && !tx_busy && left_q != 4'd0) begin
			tx_data <= data_q[cmd_pkg::BYTE_W-1:0]; // held until the next start
			data_q <= data_q >> cmd_pkg::BYTE_W;
		end
	end

endmodule

// File: verilog/scope_settings.sv
// trigger and acquisition setting registers with clamping, spi request and trigger prime strobes
`timescale 1ns/10ps

module scope_settings (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          cmd_valid,
	input  logic [cmd_pkg::BYTE_W-1:0]    cmd_op,
	input  cmd_pkg::arg_word_u            cmd_arg,
	input  logic [cmd_pkg::BYTE_W-1:0]    my_id,
	output logic [cmd_pkg::BYTE_W-1:0]    trigthresh,    // normal threshold
	output logic [cmd_pkg::BYTE_W-1:0]    trigthresh2,   // high threshold
	output logic [cmd_pkg::N_CHAN-1:0]    triggertype,
	output logic [cmd_pkg::N_CHAN-1:0]    trigchannels,
	output logic [cmd_pkg::TOT_W-1:0]     triggertot,
	output logic [cmd_pkg::RAM_W-1:0]     triggerpoint,
	output logic [cmd_pkg::RAM_W-1:0]     nsmp,          // samples to send
	output logic [cmd_pkg::BYTE_W-1:0]    downsample,    // log2 of the decimation
	output logic                          rollingtrigger,
	output logic                          highres,
	output logic                          use_ext_trig,
	output logic                          spi_send,
	output logic [2*cmd_pkg::BYTE_W-1:0]  spi_data,
	output logic                          prime_trigger
);

	logic [2*cmd_pkg::BYTE_W-1:0] word;       // two-byte value
	logic [cmd_pkg::BYTE_W-1:0]   lo;         // one-byte value
	logic [cmd_pkg::RAM_W-1:0]    tp_clamped;
	logic [cmd_pkg::RAM_W-1:0]    nsmp_new;
	logic                         tp_too_late; // trigger point would not fit the new window
	logic [cmd_pkg::BYTE_W-1:0]   ds_clamped;
	logic                         own_chan;    // channel number maps onto this board

	assign word = cmd_arg.w;
	assign lo = cmd_arg.b.lo;
	assign nsmp_new = word[cmd_pkg::RAM_W-1:0];

	always_comb begin
		if (word > cmd_pkg::TRIG_POINT_MAX)
			tp_clamped = cmd_pkg::TRIG_POINT_MAX;
		else if (word < cmd_pkg::TRIG_POINT_MIN)
			tp_clamped = cmd_pkg::TRIG_POINT_MIN;
		else
			tp_clamped = word[cmd_pkg::RAM_W-1:0];
	end

	// tp > nsmp - 5 without wrapping below zero
	assign tp_too_late = ({1'b0, triggerpoint} + 13'd5) > {1'b0, nsmp_new};
	assign ds_clamped = (lo > cmd_pkg::DOWNSAMPLE_MAX) ? cmd_pkg::DOWNSAMPLE_MAX : lo;
	assign own_chan = ((lo >> 2) == my_id); // 4 channels per board

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			trigthresh <= cmd_pkg::THRESH_RST;
			trigthresh2 <= cmd_pkg::THRESH2_RST;
			triggertype <= cmd_pkg::TRIG_TYPE_RST;
			trigchannels <= cmd_pkg::TRIG_CHAN_RST;
			triggertot <= '0;
			triggerpoint <= cmd_pkg::TRIG_POINT_RST;
			nsmp <= '0;
			downsample <= 8'd1;
			rollingtrigger <= 1'b1; // free running until told otherwise
			highres <= 1'b0;
			use_ext_trig <= 1'b0;
			spi_send <= 1'b0;
			prime_trigger <= 1'b0;
		end else begin
			spi_send <= 1'b0;
			prime_trigger <= 1'b0;
			if (cmd_valid) begin
				case (cmd_op)
					cmd_pkg::OP_TRIG_POINT: triggerpoint <= tp_clamped;
					cmd_pkg::OP_NSMP: begin
						nsmp <= nsmp_new;
						if (tp_too_late)
							triggerpoint <= nsmp_new >> 1; // recentre
					end
					cmd_pkg::OP_DOWNSAMPLE: downsample <= ds_clamped;
					cmd_pkg::OP_THRESH: trigthresh <= lo;
					cmd_pkg::OP_THRESH2: trigthresh2 <= lo;
					cmd_pkg::OP_TRIG_TYPE: triggertype <= lo[cmd_pkg::N_CHAN-1:0];
					cmd_pkg::OP_TOT: triggertot <= word[cmd_pkg::TOT_W-1:0];
					cmd_pkg::OP_TRIG_CHAN: begin
						if (own_chan)
							trigchannels[lo[1:0]] <= ~trigchannels[lo[1:0]];
					end
					cmd_pkg::OP_SPI: spi_send <= 1'b1;
					cmd_pkg::OP_PRIME: prime_trigger <= 1'b1; // every board arms together
					cmd_pkg::OP_ROLL_ON: rollingtrigger <= 1'b1;
					cmd_pkg::OP_ROLL_OFF: rollingtrigger <= 1'b0;
					cmd_pkg::OP_HIGHRES: highres <= ~highres;
					cmd_pkg::OP_EXT_TRIG: use_ext_trig <= ~use_ext_trig;
					default: begin
					end
				endcase
			end
		end
	end

	// adc register write, top bit 0 selects write
	always_ff @(posedge clk) begin
		if (cmd_valid && cmd_op == cmd_pkg::OP_SPI)
			spi_data <= {1'b0, word[2*cmd_pkg::BYTE_W-2:0]};
	end

endmodule

// File: verilog/chain_ctrl.sv
// daisy chain state: board id, clock master select, first/last flags, serial passthrough
`timescale 1ns/10ps

module chain_ctrl (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          cmd_valid,
	input  logic [cmd_pkg::BYTE_W-1:0]    cmd_op,
	input  cmd_pkg::arg_word_u            cmd_arg,
	output logic [cmd_pkg::BYTE_W-1:0]    my_id,
	output logic                          master_clock, // 0 runs on own clock, 1 follows upstream
	output logic                          first_board,
	output logic                          last_board,
	output logic                          passthrough   // uart bytes belong to a board further down
);

	logic [cmd_pkg::BYTE_W-1:0] arg; // all chain commands carry one byte
	logic                       is_me;
	logic                       before_target; // target sits further down the chain

	assign arg = cmd_arg.b.lo;
	assign is_me = (arg == my_id);
	assign before_target = (my_id < arg);

	assign first_board = (my_id == '0); // board 0 heads the chain

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			my_id <= cmd_pkg::RESET_ID;
			master_clock <= 1'b0;
			last_board <= 1'b0;
			passthrough <= 1'b0;
		end else if (cmd_valid) begin
			case (cmd_op)
				cmd_pkg::OP_SET_ID: begin
					my_id <= arg;
					master_clock <= (arg != '0); // everyone but the head is a clock slave
				end
				cmd_pkg::OP_SET_LAST: begin
					last_board <= is_me;
				end
				cmd_pkg::OP_READ_SEL: begin
					if (is_me || arg == cmd_pkg::BROADCAST_ID)
						passthrough <= 1'b0; // we answer
					else if (before_target)
						passthrough <= 1'b1; // relay for a board below us
				end
				cmd_pkg::OP_ACTIVE_SEL: begin
					// same selection, no broadcast
					if (is_me)
						passthrough <= 1'b0;
					else if (before_target)
						passthrough <= 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// File: verilog/cmd_collect.sv
// command byte collector with chain forwarding and command strobe
`timescale 1ns/10ps

module cmd_collect (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          rx_ready,    // one-cycle strobe from uart rx
	input  logic [cmd_pkg::BYTE_W-1:0]    rx_data,
	input  logic                          passthrough, // another board is being read out
	input  logic                          reply_busy,  // uart reply in progress
	output logic                          com_valid,   // byte to the next board
	output logic [cmd_pkg::BYTE_W-1:0]    com_data,
	output logic                          cmd_valid,   // complete command
	output logic [cmd_pkg::BYTE_W-1:0]    cmd_op,
	output cmd_pkg::arg_word_u            cmd_arg
);

	logic [1:0] args_left; // argument bytes still expected, 0 means waiting for an opcode
	logic [1:0] n_args;    // arg count of the incoming byte seen as an opcode
	logic       is_reply;  // incoming opcode is a readout command
	logic       add_one;   // collecting for OP_SET_ID
	logic       take;      // byte accepted this cycle

	assign n_args = cmd_pkg::arg_count(rx_data);
	assign is_reply = cmd_pkg::is_reply_op(rx_data);

	// reply_busy rises a cycle after the strobe, so cover that cycle too
	assign take = rx_ready && !reply_busy && !(cmd_valid && cmd_pkg::is_reply_op(cmd_op));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			args_left <= 2'd0;
			add_one <= 1'b0;
			com_valid <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			com_valid <= 1'b0; // pulses only
			cmd_valid <= 1'b0;
			if (take) begin
				if (args_left != 2'd0) begin
					com_valid <= 1'b1; // arguments always go down the chain
					args_left <= args_left - 2'd1;
					cmd_valid <= (args_left == 2'd1); // last byte completes it
				end else if (n_args != cmd_pkg::ARG_UNKNOWN) begin
					// readouts go down the chain or get answered here, never both
					com_valid <= !is_reply || passthrough;
					cmd_valid <= (n_args == 2'd0) && !(is_reply && passthrough);
					args_left <= n_args;
					add_one <= (rx_data == cmd_pkg::OP_SET_ID);
				end
			end
		end
	end

	// forwarded byte, opcode and argument word
	always_ff @(posedge clk) begin
		if (take) begin
			if (args_left != 2'd0) begin
				com_data <= add_one ? rx_data + 8'd1 : rx_data; // next board gets the next id
				cmd_arg.w <= {cmd_arg.b.lo, rx_data}; // shift in, big-endian
			end else begin
				com_data <= rx_data;
				cmd_op <= rx_data;
				cmd_arg.w <= '0; // single-byte args end up in lo
			end
		end
	end

endmodule

// File: verilog/cmd_pkg.sv
// opcode map, field widths, setting limits, reset values, argument decode helpers and argument word
package cmd_pkg;

	localparam int BYTE_W = 8; // every chain and uart byte
	localparam int RAM_W = 12; // sample address, 4096 deep
	localparam int TOT_W = 13; // trigger time over threshold
	localparam int N_CHAN = 4; // channels per board
	localparam int CHIP_ID_BYTES = 8;
	localparam int CHIP_ID_W = CHIP_ID_BYTES * BYTE_W;
	localparam logic [1:0] ARG_UNKNOWN = 2'd3; // arg_count result for opcodes we ignore

	// chain setup, one argument byte each
	localparam logic [BYTE_W-1:0] OP_SET_ID = 8'd50; // arg is the id, forwarded +1
	localparam logic [BYTE_W-1:0] OP_READ_SEL = 8'd51;
	localparam logic [BYTE_W-1:0] OP_SET_LAST = 8'd52;
	localparam logic [BYTE_W-1:0] OP_ACTIVE_SEL = 8'd53;

	localparam logic [BYTE_W-1:0] OP_PRIME = 8'd100;
	localparam logic [BYTE_W-1:0] OP_ROLL_ON = 8'd101;
	localparam logic [BYTE_W-1:0] OP_ROLL_OFF = 8'd102;
	localparam logic [BYTE_W-1:0] OP_TRIG_POINT = 8'd121; // 2 bytes
	localparam logic [BYTE_W-1:0] OP_NSMP = 8'd122; // 2 bytes
	localparam logic [BYTE_W-1:0] OP_DOWNSAMPLE = 8'd124;
	localparam logic [BYTE_W-1:0] OP_THRESH = 8'd127;
	localparam logic [BYTE_W-1:0] OP_TRIG_TYPE = 8'd128;
	localparam logic [BYTE_W-1:0] OP_TOT = 8'd129; // 2 bytes
	localparam logic [BYTE_W-1:0] OP_TRIG_CHAN = 8'd130;
	localparam logic [BYTE_W-1:0] OP_SPI = 8'd131; // 2 bytes, adc register write
	localparam logic [BYTE_W-1:0] OP_THRESH2 = 8'd140;
	localparam logic [BYTE_W-1:0] OP_HIGHRES = 8'd143;
	localparam logic [BYTE_W-1:0] OP_EXT_TRIG = 8'd144;

	// readout commands, answered over the uart
	localparam logic [BYTE_W-1:0] OP_DELAY_CNT = 8'd132;
	localparam logic [BYTE_W-1:0] OP_CARRY_CNT = 8'd133;
	localparam logic [BYTE_W-1:0] OP_CHIP_ID = 8'd142;
	localparam logic [BYTE_W-1:0] OP_FW_VER = 8'd147;

	localparam logic [BYTE_W-1:0] FW_VERSION = 8'd18;
	localparam logic [BYTE_W-1:0] BROADCAST_ID = 8'd255; // all boards read out
	localparam logic [BYTE_W-1:0] RESET_ID = 8'd200; // not yet numbered
	localparam logic [RAM_W-1:0] TRIG_POINT_MIN = 12'd4;
	localparam logic [RAM_W-1:0] TRIG_POINT_MAX = 12'd4080; // 16 short of the top
	localparam logic [BYTE_W-1:0] DOWNSAMPLE_MAX = 8'd30;

	localparam logic [BYTE_W-1:0] THRESH_RST = 8'd128; // mid scale
	localparam logic [BYTE_W-1:0] THRESH2_RST = 8'd255;
	localparam logic [N_CHAN-1:0] TRIG_TYPE_RST = 4'd1; // rising edge only
	localparam logic [N_CHAN-1:0] TRIG_CHAN_RST = 4'd15; // all channels armed
	localparam logic [RAM_W-1:0] TRIG_POINT_RST = 12'd1024; // quarter of the buffer

	// two-byte argument, first byte received lands in hi
	typedef union packed {
		struct packed {
			logic [BYTE_W-1:0] hi;
			logic [BYTE_W-1:0] lo; // single-byte args sit here
		} b;
		logic [2*BYTE_W-1:0] w; // big-endian value
	} arg_word_u;

	function automatic logic [1:0] arg_count(input logic [BYTE_W-1:0] op);
		logic [1:0] n;
		case (op)
			OP_PRIME, OP_ROLL_ON, OP_ROLL_OFF, OP_HIGHRES, OP_EXT_TRIG,
			OP_DELAY_CNT, OP_CARRY_CNT, OP_CHIP_ID, OP_FW_VER: n = 2'd0;
			OP_SET_ID, OP_READ_SEL, OP_SET_LAST, OP_ACTIVE_SEL, OP_DOWNSAMPLE,
			OP_THRESH, OP_TRIG_TYPE, OP_TRIG_CHAN, OP_THRESH2: n = 2'd1;
			OP_TRIG_POINT, OP_NSMP, OP_TOT, OP_SPI: n = 2'd2;
			default: n = ARG_UNKNOWN;
		endcase
		return n;
	endfunction

	function automatic logic is_reply_op(input logic [BYTE_W-1:0] op);
		return op inside {OP_DELAY_CNT, OP_CARRY_CNT, OP_CHIP_ID, OP_FW_VER};
	endfunction

endpackage
